/* rtl/ethpipe_pkg.sv */
package ethpipe_pkg;

  // --------------------------------------------------
  // Queue sizing
  // --------------------------------------------------
  localparam int Q_DEPTH     = 64;
  localparam int Q_CNT_W     = 7;
  // Enough room for a 44-byte frame plus its header
  localparam int RX_MIN_FREE = 24;

  // --------------------------------------------------
  // Register map, in 16-bit words of the slave address
  // --------------------------------------------------
  localparam logic [5:0] REG_CNT0     = 6'h02;
  localparam logic [5:0] REG_CNT1     = 6'h03;
  localparam logic [5:0] REG_CNT2     = 6'h04;
  localparam logic [5:0] REG_CNT3     = 6'h05;
  localparam logic [5:0] REG_STATUS   = 6'h08;
  localparam logic [5:0] REG_LEN_LO   = 6'h0A;
  localparam logic [5:0] REG_LEN_HI   = 6'h0B;
  localparam logic [5:0] REG_START_LO = 6'h10;
  localparam logic [5:0] REG_START_HI = 6'h11;
  localparam logic [5:0] REG_CUR_LO   = 6'h12;
  localparam logic [5:0] REG_CUR_HI   = 6'h13;
  localparam logic [5:0] REG_DROPS    = 6'h1C;

  localparam logic [21:0] DMA_LEN_RST   = 22'h01_0000;
  localparam logic [31:0] DMA_START_RST = 32'h1000_0000;

  // FSM encodings
  localparam logic [1:0] FR_IDLE     = 2'd0;
  localparam logic [1:0] FR_ACCEPT   = 2'd1;
  localparam logic [1:0] FR_DISCARD  = 2'd2;
  localparam logic [1:0] WR_IDLE     = 2'd0;
  localparam logic [1:0] WR_REQ      = 2'd1;
  localparam logic [1:0] WR_WAIT_LOW = 2'd2;

  // --------------------------------------------------
  // Queue entry
  // --------------------------------------------------
  typedef enum logic [1:0] {
    TAG_HDR      = 2'd0,
    TAG_DATA     = 2'd1,
    TAG_LAST     = 2'd2,
    TAG_LAST_ODD = 2'd3
  } entry_tag_e;

  typedef union packed {
    struct packed {
      logic [15:0] timestamp;
    } hdr;
    struct packed {
      logic [7:0] byte_hi;
      logic [7:0] byte_lo;
    } dat;
  } entry_body_u;

  typedef struct packed {
    entry_tag_e  tag;
    entry_body_u body;
  } rx_entry_t;

  // Slave bus request
  typedef struct packed {
    logic        ce;
    logic        we;
    logic [5:0]  adr;
    logic [1:0]  sel;
    logic [15:0] dat;
  } slv_req_t;

  // Host write command, byte address
  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] dat;
  } mst_cmd_t;

endpackage

/* rtl/gmii_rx_framer.sv */
module gmii_rx_framer (
  input  logic                            clk_125,
  input  logic                            sys_rst,
  input  logic                            gmii_rx_dv_i,
  input  logic [7:0]                      gmii_rxd_i,
  input  logic [63:0]                     global_counter_i,
  input  logic [ethpipe_pkg::Q_CNT_W-1:0] q_count_i,
  output ethpipe_pkg::rx_entry_t          q_din_o,
  output logic                            q_wr_en_o,
  output logic                            drop_pulse_o
);
  import ethpipe_pkg::*;

  logic [1:0]  state;
  logic [15:0] ts_q;
  logic [7:0]  hi_byte;
  logic        have_hi;
  logic [15:0] pair_q;
  logic        pair_valid;
  logic        hdr_pend;
  logic        last_pend;
  entry_tag_e  last_tag;
  logic        frame_fits;

  assign frame_fits = q_count_i <= Q_CNT_W'(Q_DEPTH - RX_MIN_FREE);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state        <= FR_IDLE;
      have_hi      <= 1'b0;
      pair_valid   <= 1'b0;
      hdr_pend     <= 1'b0;
      last_pend    <= 1'b0;
      drop_pulse_o <= 1'b0;
    end else begin
      hdr_pend     <= 1'b0;
      last_pend    <= 1'b0;
      pair_valid   <= 1'b0;
      drop_pulse_o <= 1'b0;
      case (state)
        FR_IDLE: begin
          if (gmii_rx_dv_i) begin
            if (frame_fits) begin
              hdr_pend <= 1'b1;
              have_hi  <= 1'b1;
              state    <= FR_ACCEPT;
            end else begin
              drop_pulse_o <= 1'b1;
              state        <= FR_DISCARD;
            end
          end
        end
        FR_ACCEPT: begin
          if (gmii_rx_dv_i) begin
            pair_valid <= have_hi;
            have_hi    <= ~have_hi;
          end else begin
            last_pend <= 1'b1;
            have_hi   <= 1'b0;
            state     <= FR_IDLE;
          end
        end
        FR_DISCARD: begin
          if (!gmii_rx_dv_i)
            state <= FR_IDLE;
        end
        default: state <= FR_IDLE;
      endcase
    end
  end

  // Byte pairing and timestamp capture
  always_ff @(posedge clk_125) begin
    if (state == FR_IDLE && gmii_rx_dv_i)
      ts_q <= global_counter_i[15:0];
    if (gmii_rx_dv_i && !have_hi)
      hi_byte <= gmii_rxd_i;
    if (state == FR_ACCEPT) begin
      if (have_hi)
        pair_q <= {hi_byte, gmii_rx_dv_i ? gmii_rxd_i : 8'h00};
      if (!gmii_rx_dv_i)
        last_tag <= have_hi ? TAG_LAST_ODD : TAG_LAST;
    end
  end

  // A held pair goes out as data once the frame is seen to continue
  always_comb begin
    q_wr_en_o = hdr_pend | last_pend | (pair_valid & gmii_rx_dv_i);
    if (hdr_pend) begin
      q_din_o.tag                = TAG_HDR;
      q_din_o.body.hdr.timestamp = ts_q;
    end else begin
      q_din_o.tag                = last_pend ? last_tag : TAG_DATA;
      q_din_o.body.dat.byte_hi   = pair_q[15:8];
      q_din_o.body.dat.byte_lo   = pair_q[7:0];
    end
  end

  // Admission control keeps the queue from overflowing
  a_no_write_full: assert property (@(posedge clk_125) disable iff (sys_rst)
    q_wr_en_o |-> q_count_i != Q_CNT_W'(Q_DEPTH));

endmodule

/* rtl/rx_word_fifo.sv */
module rx_word_fifo (
  input  logic                            clk_125,
  input  logic                            sys_rst,
  input  logic                            wr_en_i,
  input  ethpipe_pkg::rx_entry_t          din_i,
  input  logic                            rd_en_i,
  output ethpipe_pkg::rx_entry_t          dout_o,
  output logic                            empty_o,
  output logic [ethpipe_pkg::Q_CNT_W-1:0] count_o
);
  import ethpipe_pkg::*;

  rx_entry_t                    mem [Q_DEPTH];
  logic [$clog2(Q_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(Q_DEPTH)-1:0]   rd_ptr;
  logic                         do_wr;
  logic                         do_rd;

  assign do_wr   = wr_en_i && count_o != Q_CNT_W'(Q_DEPTH);
  assign do_rd   = rd_en_i && !empty_o;
  assign empty_o = count_o == '0;

  // Show-ahead head entry
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  always_ff @(posedge clk_125) begin
    if (do_wr)
      mem[wr_ptr] <= din_i;
  end

  a_no_read_empty: assert property (@(posedge clk_125) disable iff (sys_rst)
    rd_en_i |-> !empty_o);

endmodule

/* rtl/dma_frame_writer.sv */
module dma_frame_writer (
  input  logic                   clk_125,
  input  logic                   sys_rst,
  input  ethpipe_pkg::rx_entry_t q_dout_i,
  input  logic                   q_empty_i,
  input  logic                   dma_enable_i,
  input  logic [31:0]            dma_start_i,
  input  logic [21:0]            dma_length_i,
  input  logic                   mst_ack_i,
  output logic                   q_rd_en_o,
  output ethpipe_pkg::mst_cmd_t  mst_cmd_o,
  output logic                   mst_req_o,
  output logic [31:0]            dma_cur_o,
  output logic                   frame_done_o
);
  import ethpipe_pkg::*;

  logic [1:0]  state;
  logic [21:0] offset;
  logic [21:0] offset_nxt;
  logic        enable_q;
  logic        cmd_last;
  logic [15:0] cmd_dat;

  // Pop only with ack low, and not on the cycle the enable rises
  assign q_rd_en_o = state == WR_IDLE && dma_enable_i && enable_q &&
                     !q_empty_i && !mst_ack_i;

  assign offset_nxt = (offset + 22'd2 >= dma_length_i) ? '0 : offset + 22'd2;
  assign dma_cur_o  = dma_start_i + {10'd0, offset};

  // --------------------------------------------------
  // Entry decode
  // --------------------------------------------------
  always_comb begin
    case (q_dout_i.tag)
      TAG_HDR:      cmd_dat = q_dout_i.body.hdr.timestamp;
      TAG_LAST_ODD: cmd_dat = {q_dout_i.body.dat.byte_hi, 8'h00};
      default:      cmd_dat = {q_dout_i.body.dat.byte_hi, q_dout_i.body.dat.byte_lo};
    endcase
  end

  // --------------------------------------------------
  // Four-phase handshake
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state        <= WR_IDLE;
      mst_req_o    <= 1'b0;
      frame_done_o <= 1'b0;
      offset       <= '0;
      enable_q     <= 1'b0;
    end else begin
      enable_q     <= dma_enable_i;
      frame_done_o <= 1'b0;
      if (dma_enable_i && !enable_q)
        offset <= '0;
      case (state)
        WR_IDLE: begin
          if (q_rd_en_o) begin
            offset    <= offset_nxt;
            mst_req_o <= 1'b1;
            state     <= WR_REQ;
          end
        end
        WR_REQ: begin
          if (mst_ack_i) begin
            mst_req_o <= 1'b0;
            state     <= WR_WAIT_LOW;
          end
        end
        WR_WAIT_LOW: begin
          if (!mst_ack_i) begin
            frame_done_o <= cmd_last;
            state        <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Command held for the whole handshake
  always_ff @(posedge clk_125) begin
    if (q_rd_en_o) begin
      mst_cmd_o.addr <= dma_cur_o;
      mst_cmd_o.dat  <= cmd_dat;
      cmd_last       <= q_dout_i.tag == TAG_LAST || q_dout_i.tag == TAG_LAST_ODD;
    end
  end

  a_cmd_stable: assert property (@(posedge clk_125) disable iff (sys_rst)
    mst_req_o && !mst_ack_i |=> $stable(mst_cmd_o));

endmodule

/* rtl/mmio_regs.sv */
module mmio_regs (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  input  ethpipe_pkg::slv_req_t slv_req_i,
  input  logic [31:0]           dma_cur_i,
  input  logic                  frame_done_i,
  input  logic                  drop_pulse_i,
  output logic [15:0]           slv_dat_o,
  output logic [63:0]           global_counter_o,
  output logic                  dma_enable_o,
  output logic [31:0]           dma_start_o,
  output logic [21:0]           dma_length_o,
  output logic                  sys_intr_o
);
  import ethpipe_pkg::*;

  logic [7:0]  dma_status;
  logic [15:0] drops;
  logic [15:0] rd_word;
  logic        wr_cyc;
  logic        rd_cyc;

  assign wr_cyc       = slv_req_i.ce & slv_req_i.we;
  assign rd_cyc       = slv_req_i.ce & ~slv_req_i.we;
  assign dma_enable_o = dma_status[0];
  assign sys_intr_o   = dma_status[3];

  always_ff @(posedge clk_125) begin
    if (sys_rst)
      global_counter_o <= '0;
    else
      global_counter_o <= global_counter_o + 64'd1;
  end

  // --------------------------------------------------
  // Read decode, low byte of each field in bits 15:8
  // --------------------------------------------------
  always_comb begin
    case (slv_req_i.adr)
      REG_CNT0:     rd_word = {global_counter_o[7:0], global_counter_o[15:8]};
      REG_CNT1:     rd_word = {global_counter_o[23:16], global_counter_o[31:24]};
      REG_CNT2:     rd_word = {global_counter_o[39:32], global_counter_o[47:40]};
      REG_CNT3:     rd_word = {global_counter_o[55:48], global_counter_o[63:56]};
      REG_STATUS:   rd_word = {dma_status, 8'h00};
      REG_LEN_LO:   rd_word = {dma_length_o[7:0], dma_length_o[15:8]};
      REG_LEN_HI:   rd_word = {2'b00, dma_length_o[21:16], 8'h00};
      REG_START_LO: rd_word = {dma_start_o[7:0], dma_start_o[15:8]};
      REG_START_HI: rd_word = {dma_start_o[23:16], dma_start_o[31:24]};
      REG_CUR_LO:   rd_word = {dma_cur_i[7:0], dma_cur_i[15:8]};
      REG_CUR_HI:   rd_word = {dma_cur_i[23:16], dma_cur_i[31:24]};
      REG_DROPS:    rd_word = {drops[7:0], drops[15:8]};
      default:      rd_word = 16'h0000;
    endcase
  end

  always_ff @(posedge clk_125) begin
    if (sys_rst)
      slv_dat_o <= 16'h0000;
    else if (rd_cyc)
      slv_dat_o <= rd_word;
  end

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dma_status   <= 8'h00;
      dma_length_o <= DMA_LEN_RST;
      dma_start_o  <= DMA_START_RST;
      drops        <= 16'h0000;
    end else begin
      if (wr_cyc) begin
        case (slv_req_i.adr)
          REG_STATUS: begin
            if (slv_req_i.sel[1])
              dma_status <= slv_req_i.dat[15:8];
          end
          REG_LEN_LO: begin
            // Lengths and addresses stay halfword aligned
            if (slv_req_i.sel[1])
              dma_length_o[7:0] <= {slv_req_i.dat[15:9], 1'b0};
            if (slv_req_i.sel[0])
              dma_length_o[15:8] <= slv_req_i.dat[7:0];
          end
          REG_LEN_HI: begin
            if (slv_req_i.sel[1])
              dma_length_o[21:16] <= slv_req_i.dat[13:8];
          end
          REG_START_LO: begin
            if (slv_req_i.sel[1])
              dma_start_o[7:0] <= {slv_req_i.dat[15:9], 1'b0};
            if (slv_req_i.sel[0])
              dma_start_o[15:8] <= slv_req_i.dat[7:0];
          end
          REG_START_HI: begin
            if (slv_req_i.sel[1])
              dma_start_o[23:16] <= slv_req_i.dat[15:8];
            if (slv_req_i.sel[0])
              dma_start_o[31:24] <= slv_req_i.dat[7:0];
          end
          default: ;
        endcase
      end
      // Frame done wins over a status write in the same cycle
      if (frame_done_i)
        dma_status[3] <= 1'b1;
      if (drop_pulse_i && drops != 16'hFFFF)
        drops <= drops + 16'd1;
    end
  end

endmodule

/* rtl/ethpipe_lite.sv */
module ethpipe_lite (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  input  logic                  gmii_rx_dv_i,
  input  logic [7:0]            gmii_rxd_i,
  input  ethpipe_pkg::slv_req_t slv_req_i,
  input  logic                  mst_ack_i,
  output logic [15:0]           slv_dat_o,
  output ethpipe_pkg::mst_cmd_t mst_cmd_o,
  output logic                  mst_req_o,
  output logic                  sys_intr_o
);
  import ethpipe_pkg::*;

  rx_entry_t          q_din;
  rx_entry_t          q_dout;
  logic               q_wr_en;
  logic               q_rd_en;
  logic               q_empty;
  logic [Q_CNT_W-1:0] q_count;
  logic [63:0]        global_counter;
  logic               drop_pulse;
  logic               dma_enable;
  logic [31:0]        dma_start;
  logic [21:0]        dma_length;
  logic [31:0]        dma_cur;
  logic               frame_done;

  gmii_rx_framer u_framer (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .gmii_rx_dv_i     (gmii_rx_dv_i),
    .gmii_rxd_i       (gmii_rxd_i),
    .global_counter_i (global_counter),
    .q_count_i        (q_count),
    .q_din_o          (q_din),
    .q_wr_en_o        (q_wr_en),
    .drop_pulse_o     (drop_pulse)
  );

  rx_word_fifo u_rx_fifo (
    .clk_125 (clk_125),
    .sys_rst (sys_rst),
    .wr_en_i (q_wr_en),
    .din_i   (q_din),
    .rd_en_i (q_rd_en),
    .dout_o  (q_dout),
    .empty_o (q_empty),
    .count_o (q_count)
  );

  dma_frame_writer u_writer (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .q_dout_i     (q_dout),
    .q_empty_i    (q_empty),
    .dma_enable_i (dma_enable),
    .dma_start_i  (dma_start),
    .dma_length_i (dma_length),
    .mst_ack_i    (mst_ack_i),
    .q_rd_en_o    (q_rd_en),
    .mst_cmd_o    (mst_cmd_o),
    .mst_req_o    (mst_req_o),
    .dma_cur_o    (dma_cur),
    .frame_done_o (frame_done)
  );

  mmio_regs u_regs (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .slv_req_i        (slv_req_i),
    .dma_cur_i        (dma_cur),
    .frame_done_i     (frame_done),
    .drop_pulse_i     (drop_pulse),
    .slv_dat_o        (slv_dat_o),
    .global_counter_o (global_counter),
    .dma_enable_o     (dma_enable),
    .dma_start_o      (dma_start),
    .dma_length_o     (dma_length),
    .sys_intr_o       (sys_intr_o)
  );

endmodule

/* tests/tb_ethpipe_lite.sv */
module tb_ethpipe_lite;
  timeunit 1ns;
  timeprecision 100ps;
  import ethpipe_pkg::*;

  logic        clk_125;
  logic        sys_rst;
  logic        gmii_rx_dv_i;
  logic [7:0]  gmii_rxd_i;
  slv_req_t    slv_req_i;
  logic        mst_ack_i;
  logic [15:0] slv_dat_o;
  mst_cmd_t    mst_cmd_o;
  logic        mst_req_o;
  logic        sys_intr_o;

  int          seed = 32'h2edd;
  logic [31:0] cyc;
  bit          stall;
  mst_cmd_t    exp_q[$];
  bit          exp_last_q[$];
  mst_cmd_t    exp_cmd;
  logic        exp_valid;
  logic [15:0] host_mem [logic [31:0]];
  logic [31:0] ring_start;
  logic [21:0] ring_len;
  logic [21:0] ring_off;
  logic        en_model;
  logic [15:0] last_ts;
  int          rx_frames;
  logic        chk_en;
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  string       chk_name;
  int          err_cnt;
  int          n_tests;
  int          n_failed;
  int          test_err0;
  string       cur_test;
  bit          timed_out;
  string       timeout_what;

  ethpipe_lite u_dut (
    .clk_125      (clk_125),
    .sys_rst      (sys_rst),
    .gmii_rx_dv_i (gmii_rx_dv_i),
    .gmii_rxd_i   (gmii_rxd_i),
    .slv_req_i    (slv_req_i),
    .mst_ack_i    (mst_ack_i),
    .slv_dat_o    (slv_dat_o),
    .mst_cmd_o    (mst_cmd_o),
    .mst_req_o    (mst_req_o),
    .sys_intr_o   (sys_intr_o)
  );

  initial begin
    clk_125 = 1'b0;
    forever #5 clk_125 = ~clk_125;
  end

  // Mirrors the free-running counter
  always @(posedge clk_125) begin
    if (sys_rst)
      cyc <= '0;
    else
      cyc <= cyc + 32'd1;
  end

  // --------------------------------------------------
  // Checking
  // --------------------------------------------------
  a_value: assert property (@(posedge clk_125) chk_en |-> chk_got == chk_exp)
    else begin
      $display("MISMATCH %0s got %h expected %h", chk_name, chk_got, chk_exp);
      err_cnt++;
    end

  a_cmd_match: assert property (@(posedge clk_125) disable iff (sys_rst)
    mst_req_o && exp_valid |-> mst_cmd_o == exp_cmd)
    else begin
      $display("MISMATCH mst_cmd_o got %h expected %h", mst_cmd_o, exp_cmd);
      err_cnt++;
    end

  a_no_extra_req: assert property (@(posedge clk_125) disable iff (sys_rst)
    $rose(mst_req_o) |-> exp_valid)
    else begin
      $display("host write request arrived while no command was expected");
      err_cnt++;
    end

  a_req_hold: assert property (@(posedge clk_125) disable iff (sys_rst)
    mst_req_o && !mst_ack_i |=> mst_req_o)
    else begin
      $display("mst_req_o dropped before the host raised ack");
      err_cnt++;
    end

  always @(posedge timed_out) begin
    $display("timeout while waiting for %0s", timeout_what);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic flag_timeout(input string what);
    timeout_what = what;
    timed_out    = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_name = name;
    chk_got  = got;
    chk_exp  = exp;
    chk_en   = 1'b1;
    @(posedge clk_125);
    #1;
    chk_en = 1'b0;
  endtask

  function automatic logic [15:0] swap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  // --------------------------------------------------
  // Expected host writes and ring model
  // --------------------------------------------------
  task automatic refresh_expect();
    exp_valid = exp_q.size() != 0;
    if (exp_valid)
      exp_cmd = exp_q[0];
  endtask

  task automatic push_cmd(input logic [15:0] dat, input bit last);
    mst_cmd_t    cmd;
    logic [21:0] nxt;
    cmd.addr = ring_start + {10'd0, ring_off};
    cmd.dat  = dat;
    exp_q.push_back(cmd);
    exp_last_q.push_back(last);
    nxt = ring_off + 22'd2;
    ring_off = (nxt == ring_len) ? 22'd0 : nxt;
    refresh_expect();
  endtask

  task automatic bus_access(input logic we, input logic [5:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdata);
    slv_req_i.ce  = 1'b1;
    slv_req_i.we  = we;
    slv_req_i.adr = adr;
    slv_req_i.sel = 2'b11;
    slv_req_i.dat = dat;
    @(posedge clk_125);
    #1;
    slv_req_i.ce = 1'b0;
    slv_req_i.we = 1'b0;
    rdata = slv_dat_o;
  endtask

  task automatic config_ring(input logic [31:0] start, input logic [21:0] len);
    logic [15:0] rd;
    logic [31:0] len32;
    len32 = {10'd0, len};
    bus_access(1'b1, REG_START_LO, swap16(start[15:0]), rd);
    bus_access(1'b1, REG_START_HI, swap16(start[31:16]), rd);
    bus_access(1'b1, REG_LEN_LO, swap16(len32[15:0]), rd);
    bus_access(1'b1, REG_LEN_HI, swap16(len32[31:16]), rd);
    ring_start = start;
    ring_len   = len;
  endtask

  task automatic set_status(input logic [7:0] v);
    logic [15:0] rd;
    bus_access(1'b1, REG_STATUS, {v, 8'h00}, rd);
    if (v[0] && !en_model)
      ring_off = '0;
    en_model = v[0];
  endtask

  task automatic mark_frame_start(output logic [15:0] ts);
    ts = cyc[15:0];
  endtask

  task automatic send_frame(input int nbytes);
    logic [7:0] payload [64];
    int         i;
    for (i = 0; i < nbytes; i++)
      payload[i] = 8'($random(seed));
    mark_frame_start(last_ts);
    push_cmd(last_ts, 1'b0);
    for (i = 0; i + 1 < nbytes; i += 2)
      push_cmd({payload[i], payload[i+1]}, i + 2 >= nbytes);
    if (nbytes % 2 == 1)
      push_cmd({payload[nbytes-1], 8'h00}, 1'b1);
    for (i = 0; i < nbytes; i++) begin
      gmii_rxd_i   = payload[i];
      gmii_rx_dv_i = 1'b1;
      @(posedge clk_125);
      #1;
    end
    gmii_rx_dv_i = 1'b0;
    gmii_rxd_i   = 8'h00;
    // Interframe gap
    repeat (12) begin
      @(posedge clk_125);
      #1;
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk_125);
      #1;
      n++;
    end
    if (exp_q.size() != 0)
      flag_timeout("host writes to drain");
  endtask

  // Frame done of the last handshake lands a few cycles after the drain
  task automatic wait_intr(input int limit);
    int n;
    n = 0;
    while (!sys_intr_o && n < limit) begin
      @(posedge clk_125);
      #1;
      n++;
    end
    if (!sys_intr_o)
      flag_timeout("sys_intr_o to rise");
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
    n_tests++;
  endtask

  task automatic end_test();
    if (err_cnt == test_err0) begin
      $display("test %0s: ok", cur_test);
    end else begin
      $display("test %0s: failed, %0d errors", cur_test, err_cnt - test_err0);
      n_failed++;
    end
  endtask

  // Host responder with a random ack delay
  initial begin
    int d;
    int n;
    forever begin
      @(posedge clk_125);
      #1;
      if (!sys_rst && mst_req_o && !stall) begin
        d = int'({$random(seed)} % 4);
        repeat (d) begin
          @(posedge clk_125);
          #1;
        end
        mst_ack_i = 1'b1;
        host_mem[mst_cmd_o.addr] = mst_cmd_o.dat;
        n = 0;
        while (mst_req_o && n < 50) begin
          @(posedge clk_125);
          #1;
          n++;
        end
        if (mst_req_o)
          flag_timeout("mst_req_o to drop");
        mst_ack_i = 1'b0;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          if (exp_last_q.pop_front())
            rx_frames++;
        end
        refresh_expect();
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [15:0] rd;
    logic [15:0] w1;
    logic [15:0] w2;
    logic [15:0] drops0;
    logic [21:0] off_save;
    logic [31:0] nxt_addr;
    int          k;
    int          sent;
    int          keep;
    bit          dropped;
    sys_rst      = 1'b1;
    gmii_rx_dv_i = 1'b0;
    gmii_rxd_i   = 8'h00;
    slv_req_i    = '0;
    mst_ack_i    = 1'b0;
    chk_en       = 1'b0;
    stall        = 1'b0;
    en_model     = 1'b0;
    ring_off     = '0;
    ring_start   = DMA_START_RST;
    ring_len     = DMA_LEN_RST;
    exp_valid    = 1'b0;
    repeat (5) @(posedge clk_125);
    #1;
    sys_rst = 1'b0;

    start_test("register readback");
    config_ring(32'h2345_6780, 22'h02_3456);
    bus_access(1'b0, REG_LEN_LO, 16'h0, rd);
    check_value("slv_dat_o REG_LEN_LO", {16'h0, rd}, {16'h0, swap16(16'h3456)});
    bus_access(1'b0, REG_LEN_HI, 16'h0, rd);
    check_value("slv_dat_o REG_LEN_HI", {16'h0, rd}, {16'h0, swap16(16'h0002)});
    bus_access(1'b0, REG_START_LO, 16'h0, rd);
    check_value("slv_dat_o REG_START_LO", {16'h0, rd}, {16'h0, swap16(16'h6780)});
    bus_access(1'b0, REG_START_HI, 16'h0, rd);
    check_value("slv_dat_o REG_START_HI", {16'h0, rd}, {16'h0, swap16(16'h2345)});
    for (k = 0; k < 4; k++) begin
      bus_access(1'b0, REG_CNT0 + 6'(k), 16'h0, w1);
      bus_access(1'b0, REG_CNT0 + 6'(k), 16'h0, w2);
      check_value("slv_dat_o counter nondecreasing",
                  32'(swap16(w2) >= swap16(w1)), 32'd1);
    end
    bus_access(1'b0, REG_CNT0, 16'h0, w1);
    bus_access(1'b0, REG_CNT0, 16'h0, w2);
    check_value("slv_dat_o counter advances", 32'(swap16(w2) > swap16(w1)), 32'd1);
    bus_access(1'b0, 6'h01, 16'h0, rd);
    check_value("slv_dat_o unmapped 0x01", {16'h0, rd}, 32'h0);
    bus_access(1'b0, 6'h1F, 16'h0, rd);
    check_value("slv_dat_o unmapped 0x1F", {16'h0, rd}, 32'h0);
    end_test();

    start_test("even frame");
    config_ring(32'h1000_0000, 22'h00_1000);
    set_status(8'h01);
    send_frame(20);
    wait_drained(500);
    wait_intr(50);
    check_value("host_mem header timestamp", {16'h0, host_mem[32'h1000_0000]},
                {16'h0, last_ts});
    end_test();

    start_test("odd frame and interrupt");
    set_status(8'h01);
    check_value("sys_intr_o before frame", {31'h0, sys_intr_o}, 32'h0);
    send_frame(7);
    wait_drained(500);
    wait_intr(50);
    check_value("sys_intr_o after frame", {31'h0, sys_intr_o}, 32'h1);
    set_status(8'h01);
    check_value("sys_intr_o after clear", {31'h0, sys_intr_o}, 32'h0);
    end_test();

    start_test("ring wrap");
    set_status(8'h00);
    config_ring(32'h2000_0040, 22'd16);
    set_status(8'h01);
    send_frame(20);
    wait_drained(500);
    nxt_addr = ring_start + {10'd0, ring_off};
    bus_access(1'b0, REG_CUR_LO, 16'h0, rd);
    check_value("slv_dat_o REG_CUR_LO", {16'h0, rd}, {16'h0, swap16(nxt_addr[15:0])});
    bus_access(1'b0, REG_CUR_HI, 16'h0, rd);
    check_value("slv_dat_o REG_CUR_HI", {16'h0, rd}, {16'h0, swap16(nxt_addr[31:16])});
    end_test();

    start_test("back-pressure");
    set_status(8'h00);
    config_ring(32'h3000_0000, 22'h00_1000);
    set_status(8'h01);
    bus_access(1'b0, REG_DROPS, 16'h0, rd);
    drops0    = swap16(rd);
    stall     = 1'b1;
    rx_frames = 0;
    sent      = 0;
    dropped   = 1'b0;
    while (!dropped && sent < 8) begin
      keep     = exp_q.size();
      off_save = ring_off;
      send_frame(20);
      sent++;
      bus_access(1'b0, REG_DROPS, 16'h0, rd);
      if (swap16(rd) != drops0) begin
        // The frame never entered the queue
        dropped = 1'b1;
        while (exp_q.size() > keep) begin
          void'(exp_q.pop_back());
          void'(exp_last_q.pop_back());
        end
        ring_off = off_save;
        refresh_expect();
      end
    end
    check_value("drop counter moved", {31'h0, dropped}, 32'h1);
    stall = 1'b0;
    wait_drained(3000);
    bus_access(1'b0, REG_DROPS, 16'h0, rd);
    check_value("drops versus frames lost", {16'h0, swap16(rd) - drops0},
                32'(sent - rx_frames));
    end_test();

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* flist.f */
rtl/ethpipe_pkg.sv
rtl/gmii_rx_framer.sv
rtl/rx_word_fifo.sv
rtl/dma_frame_writer.sv
rtl/mmio_regs.sv
rtl/ethpipe_lite.sv
tests/tb_ethpipe_lite.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, result taken from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ethpipe_lite -Mdir obj_dir -o sim_tb -f flist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "result: fail"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "result: no pass line in log"
  exit 1
fi
echo "result: pass"
exit 0
